// ==== ex_top.f ====
+incdir+logic
+incdir+test
logic/ex_isa_pkg.sv
logic/ex_bus_pkg.sv
logic/ex_stage_reg.sv
logic/ex_alu.sv
logic/ex_mul_hilo.sv
logic/ex_top.sv
test/ex_tb.sv

// ==== logic/ex_alu.sv ====
/*
 * Logic, shift, add/sub, compare, leading-count and trap units
 * plus write-back result selection
 */

`include "ex_settings.svh"

module ex_alu (
    input  ex_bus_pkg::ex_req_t  req_i,
    input  ex_bus_pkg::word_t    mul_lo_i,
    input  ex_bus_pkg::word_t    move_i,
    output ex_bus_pkg::ex_resp_t resp_o
);

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    localparam int CNT_W = $clog2(`EX_XLEN + 1);

    word_t                  logic_res;
    word_t                  shift_res;
    word_t                  arith_res;
    word_t                  op2_mux;
    word_t                  sum;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   sub_sel;
    logic                   signed_cmp;
    logic                   op2_sign;
    logic                   ov_sum;
    logic                   lt;
    logic                   ov_hit;
    logic                   trap_hit;

    // Zeros above the first set bit, all-zero word gives XLEN
    function automatic logic [CNT_W-1:0] lead_zeros(input word_t w);
        logic [CNT_W-1:0] cnt;
        logic             found;
        cnt   = '0;
        found = 1'b0;
        for (int i = `EX_XLEN - 1; i >= 0; i--) begin
            if (w[i]) begin
                found = 1'b1;
            end else if (!found) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign shamt = req_i.reg1[`EX_SHAMT_W-1:0];

    always_comb begin
        case (req_i.aluop)
            ALU_OR:  logic_res = req_i.reg1 | req_i.reg2;
            ALU_AND: logic_res = req_i.reg1 & req_i.reg2;
            ALU_NOR: logic_res = ~(req_i.reg1 | req_i.reg2);
            ALU_XOR: logic_res = req_i.reg1 ^ req_i.reg2;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.aluop)
            ALU_SLL: shift_res = req_i.reg2 << shamt;
            ALU_SRL: shift_res = req_i.reg2 >> shamt;
            ALU_SRA: shift_res = $signed(req_i.reg2) >>> shamt;
            default: shift_res = '0;
        endcase
    end

    // One adder serves add, sub and the signed compares
    assign sub_sel    = req_i.aluop inside {ALU_SUB, ALU_SUBU, ALU_SLT, ALU_TGE, ALU_TLT};
    assign signed_cmp = req_i.aluop inside {ALU_SLT, ALU_TGE, ALU_TLT};
    assign op2_mux    = sub_sel ? (~req_i.reg2 + 1'b1) : req_i.reg2;
    assign sum        = req_i.reg1 + op2_mux;

    // Sign of the true second operand, so that subtracting INT_MIN is caught
    assign op2_sign = sub_sel ? ~req_i.reg2[`EX_XLEN-1] : req_i.reg2[`EX_XLEN-1];
    assign ov_sum   = (req_i.reg1[`EX_XLEN-1] == op2_sign)
                    && (sum[`EX_XLEN-1] != req_i.reg1[`EX_XLEN-1]);

    assign lt = signed_cmp
              ? ((req_i.reg1[`EX_XLEN-1] != req_i.reg2[`EX_XLEN-1])
                 ? req_i.reg1[`EX_XLEN-1] : sum[`EX_XLEN-1])
              : (req_i.reg1 < req_i.reg2);

    always_comb begin
        case (req_i.aluop)
            ALU_SLT, ALU_SLTU: arith_res = word_t'(lt);
            ALU_ADD, ALU_ADDU,
            ALU_SUB, ALU_SUBU: arith_res = sum;
            ALU_CLZ:           arith_res = word_t'(lead_zeros(req_i.reg1));
            ALU_CLO:           arith_res = word_t'(lead_zeros(~req_i.reg1));
            default:           arith_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.aluop)
            ALU_TEQ:           trap_hit = (req_i.reg1 == req_i.reg2);
            ALU_TNE:           trap_hit = (req_i.reg1 != req_i.reg2);
            ALU_TGE, ALU_TGEU: trap_hit = ~lt;
            ALU_TLT, ALU_TLTU: trap_hit = lt;
            default:           trap_hit = 1'b0;
        endcase
    end

    // Only the trapping add/sub forms drop the write
    assign ov_hit = (req_i.aluop inside {ALU_ADD, ALU_SUB}) && ov_sum;

    always_comb begin
        resp_o.wd   = req_i.wd;
        resp_o.wreg = req_i.wreg & ~ov_hit;
        resp_o.ov   = ov_hit;
        resp_o.trap = trap_hit;
        case (req_i.alusel)
            SEL_LOGIC: resp_o.wdata = logic_res;
            SEL_SHIFT: resp_o.wdata = shift_res;
            SEL_ARITH: resp_o.wdata = arith_res;
            SEL_MOVE:  resp_o.wdata = move_i;
            SEL_MUL:   resp_o.wdata = mul_lo_i;
            default:   resp_o.wdata = '0;
        endcase
    end

endmodule

// ==== logic/ex_bus_pkg.sv ====
/*
 * Issue, result and HI/LO structures passed through the execute stage
 */

`include "ex_settings.svh"

package ex_bus_pkg;

    import ex_isa_pkg::*;

    typedef logic [`EX_XLEN-1:0] word_t;

    // Decoded instruction entering the stage
    typedef struct packed {
        aluop_e                    aluop;
        alusel_e                   alusel;
        word_t                     reg1;
        word_t                     reg2;
        logic [`EX_REG_ADDR_W-1:0] wd;
        logic                      wreg;
    } ex_req_t;

    // Write-back request plus exception flags
    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0] wd;
        logic                      wreg;
        word_t                     wdata;
        logic                      ov;
        logic                      trap;
    } ex_resp_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

// ==== logic/ex_isa_pkg.sv ====
/*
 * ALU operation codes and result classes of the execute stage
 */

package ex_isa_pkg;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_CLZ   = 8'b1011_0000,
        ALU_CLO   = 8'b1011_0001,
        // Conditional traps, immediate forms share these codes
        ALU_TGE   = 8'b0011_0000,
        ALU_TGEU  = 8'b0011_0001,
        ALU_TLT   = 8'b0011_0010,
        ALU_TLTU  = 8'b0011_0011,
        ALU_TEQ   = 8'b0011_0100,
        ALU_TNE   = 8'b0011_0110,
        ALU_MULT  = 8'b0001_1000,
        ALU_MULTU = 8'b0001_1001,
        ALU_MUL   = 8'b1010_1001,
        ALU_MFHI  = 8'b0001_0000,
        ALU_MTHI  = 8'b0001_0001,
        ALU_MFLO  = 8'b0001_0010,
        ALU_MTLO  = 8'b0001_0011
    } aluop_e;

    // Selects which unit drives the write-back word
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

endpackage

// ==== logic/ex_mul_hilo.sv ====
/*
 * Signed/unsigned 32x32 multiplier, HI/LO register pair and MFHI/MFLO reads
 */

`include "ex_settings.svh"

module ex_mul_hilo (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_valid_i,
    input  ex_bus_pkg::ex_req_t req_i,
    output ex_bus_pkg::word_t   mul_lo_o,
    output ex_bus_pkg::word_t   move_o
);

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    localparam int PROD_W = 2 * `EX_XLEN;

    logic              signed_op;
    logic              neg_res;
    logic              hilo_we;
    word_t             op1_mag;
    word_t             op2_mag;
    logic [PROD_W-1:0] prod_mag;
    logic [PROD_W-1:0] prod;
    hilo_t             hilo_q;
    hilo_t             hilo_d;

    // Signed forms multiply magnitudes and fix the sign afterwards
    assign signed_op = req_i.aluop inside {ALU_MUL, ALU_MULT};
    assign op1_mag   = (signed_op && req_i.reg1[`EX_XLEN-1]) ? (~req_i.reg1 + 1'b1) : req_i.reg1;
    assign op2_mag   = (signed_op && req_i.reg2[`EX_XLEN-1]) ? (~req_i.reg2 + 1'b1) : req_i.reg2;
    assign prod_mag  = PROD_W'(op1_mag) * PROD_W'(op2_mag);
    assign neg_res   = signed_op && (req_i.reg1[`EX_XLEN-1] ^ req_i.reg2[`EX_XLEN-1]);
    assign prod      = neg_res ? (~prod_mag + 1'b1) : prod_mag;

    assign mul_lo_o = prod[`EX_XLEN-1:0];

    always_comb begin
        hilo_d  = hilo_q;
        hilo_we = 1'b0;
        case (req_i.aluop)
            ALU_MULT, ALU_MULTU: begin
                hilo_we = 1'b1;
                hilo_d  = hilo_t'(prod);
            end
            ALU_MTHI: begin
                hilo_we   = 1'b1;
                hilo_d.hi = req_i.reg1;
            end
            ALU_MTLO: begin
                hilo_we   = 1'b1;
                hilo_d.lo = req_i.reg1;
            end
            default: begin
            end
        endcase
    end

    // Updated at the edge that registers the writer's response
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q <= '0;
        end else if (req_valid_i && hilo_we) begin
            hilo_q <= hilo_d;
        end
    end

    always_comb begin
        case (req_i.aluop)
            ALU_MFHI: move_o = hilo_q.hi;
            ALU_MFLO: move_o = hilo_q.lo;
            default:  move_o = '0;
        endcase
    end

endmodule

// ==== logic/ex_settings.svh ====
/*
 * Word, shift-amount and register-address widths of the execute stage
 */

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Integer datapath width
`define EX_XLEN 32

// Shift amount taken from operand 1
`define EX_SHAMT_W 5

// Destination register index
`define EX_REG_ADDR_W 5

`endif

// ==== logic/ex_stage_reg.sv ====
/*
 * Valid-qualified pipeline register, generic over its payload type
 */

module ex_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            // Payload only moves with a valid beat
            if (valid_i) begin
                data_o <= data_i;
            end
        end
    end

endmodule

// ==== logic/ex_top.sv ====
/*
 * Execute stage top with input register, datapath and output register
 */

module ex_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 req_valid_i,
    input  ex_bus_pkg::ex_req_t  req_i,
    output logic                 resp_valid_o,
    output ex_bus_pkg::ex_resp_t resp_o
);

    import ex_bus_pkg::*;

    logic     req_valid_q;
    ex_req_t  req_q;
    ex_resp_t resp_d;
    word_t    mul_lo;
    word_t    move_res;

    ex_stage_reg #(.payload_t(ex_req_t)) u_req_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (req_valid_i),
        .data_i   (req_i),
        .valid_o  (req_valid_q),
        .data_o   (req_q)
    );

    ex_mul_hilo u_mul_hilo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_q),
        .req_i       (req_q),
        .mul_lo_o    (mul_lo),
        .move_o      (move_res)
    );

    ex_alu u_alu (
        .req_i    (req_q),
        .mul_lo_i (mul_lo),
        .move_i   (move_res),
        .resp_o   (resp_d)
    );

    ex_stage_reg #(.payload_t(ex_resp_t)) u_resp_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (req_valid_q),
        .data_i   (resp_d),
        .valid_o  (resp_valid_o),
        .data_o   (resp_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the execute stage testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f ex_top.f --top-module ex_tb -o ex_tb_sim
./obj_dir/ex_tb_sim | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

// ==== test/ex_ref_model.svh ====
/*
 * Reference model of the execute stage: result class per operation,
 * expected response per request and the HI/LO shadow in issue order
 */

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

hilo_t hilo_shadow = '0;

function automatic alusel_e sel_for(input aluop_e op);
    case (op)
        ALU_OR, ALU_AND, ALU_NOR, ALU_XOR: return SEL_LOGIC;
        ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_CLZ, ALU_CLO: return SEL_ARITH;
        ALU_MFHI, ALU_MFLO:                return SEL_MOVE;
        ALU_MUL:                           return SEL_MUL;
        default:                           return SEL_NOP;
    endcase
endfunction

// Run length of bits equal to lead, from the MSB down
function automatic word_t count_lead(input word_t w, input logic lead);
    int n;
    n = 0;
    while (n < `EX_XLEN && w[`EX_XLEN-1-n] == lead) begin
        n++;
    end
    return word_t'(n);
endfunction

function automatic ex_resp_t expect_resp(input ex_req_t r);
    ex_resp_t    e;
    word_t       a;
    word_t       b;
    longint      sa;
    longint      sb;
    longint      sum;
    longint      sprod;
    logic [63:0] uprod;
    int          sh;
    a     = r.reg1;
    b     = r.reg2;
    sa    = longint'($signed(a));
    sb    = longint'($signed(b));
    sh    = int'(a[`EX_SHAMT_W-1:0]);
    sprod = sa * sb;
    uprod = {32'h0, a} * {32'h0, b};
    e     = '{wd: r.wd, wreg: r.wreg, wdata: '0, ov: 1'b0, trap: 1'b0};
    case (r.aluop)
        ALU_OR:   e.wdata = a | b;
        ALU_AND:  e.wdata = a & b;
        ALU_NOR:  e.wdata = ~(a | b);
        ALU_XOR:  e.wdata = a ^ b;
        ALU_SLL:  e.wdata = b << sh;
        ALU_SRL:  e.wdata = b >> sh;
        ALU_SRA:  e.wdata = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU: begin
            sum     = (r.aluop inside {ALU_ADD, ALU_ADDU}) ? sa + sb : sa - sb;
            e.wdata = sum[31:0];
            // Out of the signed 32-bit range
            e.ov    = (r.aluop inside {ALU_ADD, ALU_SUB})
                      && (sum != longint'($signed(sum[31:0])));
        end
        ALU_SLT:   e.wdata = word_t'(sa < sb);
        ALU_SLTU:  e.wdata = word_t'(a < b);
        ALU_CLZ:   e.wdata = count_lead(a, 1'b0);
        ALU_CLO:   e.wdata = count_lead(a, 1'b1);
        ALU_TEQ:   e.trap = (a == b);
        ALU_TNE:   e.trap = (a != b);
        ALU_TGE:   e.trap = (sa >= sb);
        ALU_TGEU:  e.trap = (a >= b);
        ALU_TLT:   e.trap = (sa < sb);
        ALU_TLTU:  e.trap = (a < b);
        ALU_MUL:   e.wdata = sprod[31:0];
        ALU_MULT:  {hilo_shadow.hi, hilo_shadow.lo} = sprod;
        ALU_MULTU: {hilo_shadow.hi, hilo_shadow.lo} = uprod;
        ALU_MFHI:  e.wdata = hilo_shadow.hi;
        ALU_MFLO:  e.wdata = hilo_shadow.lo;
        ALU_MTHI:  hilo_shadow.hi = a;
        ALU_MTLO:  hilo_shadow.lo = a;
        default: begin
        end
    endcase
    if (e.ov) begin
        e.wreg = 1'b0;
    end
    return e;
endfunction

`endif

// ==== test/ex_tb.sv ====
/*
 * Execute stage testbench: clock, reset, LFSR stimulus,
 * response assertions, per-test reporting and watchdog
 */

`include "ex_settings.svh"

module ex_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    // Requests of all six tests together
    localparam int N_REQ   = 108;
    localparam int N_TESTS = 6;

    typedef struct {
        ex_resp_t resp;
        int       issue_cyc;
        int       test_id;
        bit       last;
    } pending_t;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        req_valid_i;
    ex_req_t     req_i;
    logic        resp_valid_o;
    ex_resp_t    resp_o;

    logic [31:0] lfsr_state = 32'h3bd72450;
    pending_t    exp_q[$];
    ex_resp_t    exp_resp;
    int          exp_issue;
    int          exp_test;
    logic        have_exp = 1'b0;
    int          done_test = -1;
    int          cyc = 0;
    int          err_total = 0;
    int          err_by_test[N_TESTS] = '{default: 0};
    string       test_names[N_TESTS] = '{"reset_timing", "logic_shift", "add_sub_ov",
                                         "compare_count", "traps", "mul_hilo"};

    `include "ex_ref_model.svh"

    ex_top dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'hd000_0001 : 32'h0);
        return b;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[`EX_XLEN-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic void count_error(input int tid);
        err_total++;
        if (tid >= 0) begin
            err_by_test[tid]++;
        end
    endfunction

    task automatic report_mismatch(input string name, input word_t e, input word_t a);
        $display("MISMATCH %s expected %h actual %h", name, e, a);
        count_error(exp_test);
    endtask

    task automatic report_failure(input int tid, input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        count_error(tid);
    endtask

    task automatic issue(input aluop_e op, input word_t a, input word_t b, input int tid);
        ex_req_t  r;
        pending_t p;
        word_t    wd_bits;
        wd_bits     = rand_bits(`EX_REG_ADDR_W);
        r.aluop     = op;
        r.alusel    = sel_for(op);
        r.reg1      = a;
        r.reg2      = b;
        r.wd        = wd_bits[`EX_REG_ADDR_W-1:0];
        r.wreg      = (sel_for(op) != SEL_NOP);
        p.resp      = expect_resp(r);
        p.issue_cyc = cyc;
        p.test_id   = tid;
        p.last      = 1'b0;
        exp_q.push_back(p);
        req_valid_i = 1'b1;
        req_i       = r;
        @(posedge clk);
        #0.5;
        req_valid_i = 1'b0;
    endtask

    // Same operand pairs through every operation of a group
    task automatic sweep(input aluop_e op, input word_t ca[4], input int n_rand, input int tid);
        word_t a;
        word_t b;
        for (int k = 0; k < 2 + n_rand; k++) begin
            a = (k < 2) ? ca[2*k] : rand_bits(32);
            b = (k < 2) ? ca[2*k+1] : rand_bits(32);
            issue(op, a, b, tid);
        end
    endtask

    task automatic run_tests();
        aluop_e ls_ops[7] = '{ALU_OR, ALU_AND, ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
        aluop_e as_ops[4] = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU};
        aluop_e tr_ops[6] = '{ALU_TEQ, ALU_TNE, ALU_TGE, ALU_TGEU, ALU_TLT, ALU_TLTU};
        word_t  a;
        word_t  b;
        // HI/LO still zero from reset
        issue(ALU_MFHI, 32'h1234_5678, 32'h9abc_def0, 0);
        issue(ALU_MFLO, 32'h0, 32'h0, 0);
        repeat (2) issue(ALU_ADDU, rand_bits(32), 32'h0000_0003, 0);
        exp_q[exp_q.size()-1].last = 1'b1;
        foreach (ls_ops[i]) begin
            sweep(ls_ops[i], '{32'hffff_ffff, 32'h0f0f_00ff, 32'h0000_0011, 32'h8765_4321},
                  2, 1);
        end
        issue(ALU_SRA, 32'd31, 32'h8000_0000, 1);
        issue(ALU_SRA, 32'd4, 32'h7fff_0000, 1);
        exp_q[exp_q.size()-1].last = 1'b1;
        foreach (as_ops[i]) begin
            sweep(as_ops[i], '{32'h7fff_ffff, 32'h1, 32'h8000_0000, 32'hffff_ffff}, 1, 2);
            sweep(as_ops[i], '{32'h8000_0000, 32'h1, 32'h0, 32'h8000_0000}, 0, 2);
        end
        exp_q[exp_q.size()-1].last = 1'b1;
        sweep(ALU_SLT, '{32'hffff_ffff, 32'h1, 32'h1, 32'hffff_ffff}, 1, 3);
        sweep(ALU_SLTU, '{32'hffff_ffff, 32'h1, 32'h1, 32'hffff_ffff}, 1, 3);
        issue(ALU_SLT, 32'h8000_0000, 32'h7fff_ffff, 3);
        issue(ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff, 3);
        sweep(ALU_CLZ, '{32'h0, 32'h0, 32'h0001_0000, 32'h0}, 1, 3);
        sweep(ALU_CLO, '{32'hffff_ffff, 32'h0, 32'hfff0_ffff, 32'h0}, 1, 3);
        issue(ALU_CLZ, 32'hffff_ffff, 32'h0, 3);
        issue(ALU_CLO, 32'h0, 32'h0, 3);
        exp_q[exp_q.size()-1].last = 1'b1;
        foreach (tr_ops[i]) begin
            sweep(tr_ops[i], '{32'h5, 32'h5, 32'hffff_ffff, 32'h1}, 1, 4);
            issue(tr_ops[i], 32'h1, 32'hffff_ffff, 4);
        end
        exp_q[exp_q.size()-1].last = 1'b1;
        sweep(ALU_MUL, '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h2}, 1, 5);
        a = rand_bits(32) | 32'h8000_0000;
        b = rand_bits(32);
        issue(ALU_MULT, a, b, 5);
        issue(ALU_MFHI, a, b, 5);
        issue(ALU_MFLO, a, b, 5);
        issue(ALU_MULTU, a, b, 5);
        issue(ALU_MFHI, a, b, 5);
        issue(ALU_MFLO, a, b, 5);
        // HI write must leave LO alone
        issue(ALU_MTHI, rand_bits(32), b, 5);
        issue(ALU_MFLO, a, b, 5);
        issue(ALU_MFHI, a, b, 5);
        issue(ALU_MTLO, rand_bits(32), b, 5);
        issue(ALU_MFLO, a, b, 5);
        exp_q[exp_q.size()-1].last = 1'b1;
    endtask

    // Takes the expected response off the queue a little after each edge
    always @(posedge clk) begin
        pending_t p;
        #1;
        if (done_test >= 0) begin
            if (err_by_test[done_test] == 0) begin
                $display("test %-14s ok", test_names[done_test]);
            end else begin
                $display("test %-14s %0d errors", test_names[done_test],
                         err_by_test[done_test]);
            end
            done_test = -1;
        end
        have_exp = 1'b0;
        if (resp_valid_o && exp_q.size() != 0) begin
            p         = exp_q.pop_front();
            exp_resp  = p.resp;
            exp_issue = p.issue_cyc;
            exp_test  = p.test_id;
            have_exp  = 1'b1;
            if (p.last) begin
                done_test = p.test_id;
            end
        end
    end

    assert property (@(negedge clk) !arst_n_i |-> (!resp_valid_o && resp_o == '0))
        else report_failure(-1, "response outputs not cleared during reset");
    assert property (@(negedge clk) resp_valid_o |-> have_exp)
        else report_failure(-1, "response valid with no request outstanding");
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> ((cyc - exp_issue) == 2))
        else report_failure(exp_test, "response did not arrive two edges after its request");
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> resp_o.wd == exp_resp.wd)
        else report_mismatch("resp_o.wd", word_t'(exp_resp.wd), word_t'(resp_o.wd));
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> resp_o.wreg == exp_resp.wreg)
        else report_mismatch("resp_o.wreg", word_t'(exp_resp.wreg), word_t'(resp_o.wreg));
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> resp_o.wdata == exp_resp.wdata)
        else report_mismatch("resp_o.wdata", exp_resp.wdata, resp_o.wdata);
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> resp_o.ov == exp_resp.ov)
        else report_mismatch("resp_o.ov", word_t'(exp_resp.ov), word_t'(resp_o.ov));
    assert property (@(negedge clk) (resp_valid_o && have_exp) |-> resp_o.trap == exp_resp.trap)
        else report_mismatch("resp_o.trap", word_t'(exp_resp.trap), word_t'(resp_o.trap));

    initial begin
        int n_ok;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (2) @(posedge clk);
        #0.5;
        arst_n_i = 1'b1;
        // Idle cycles out of reset with no response
        repeat (2) @(posedge clk);
        #0.5;
        run_tests();
        while (exp_q.size() != 0 || done_test >= 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        n_ok = 0;
        foreach (err_by_test[i]) begin
            if (err_by_test[i] == 0) begin
                n_ok++;
            end
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks",
                 n_ok, N_TESTS - n_ok, err_total);
        if (err_total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #((N_REQ + 20) * 4);
        $display("watchdog expired with %0d responses outstanding", exp_q.size());
        $display("*** FAILED ***");
        $finish;
    end

endmodule
